// ==== rtl/bp_settings.svh ====
`ifndef BP_SETTINGS_SVH
`define BP_SETTINGS_SVH

// Number of entries in each predictor table, must be a power of two
`define BP_ENTRIES 512

// Instruction address width
`define BP_XLEN 32

// Index width, taken from PC bits [BP_INDEX_W:1]
`define BP_INDEX_W $clog2(`BP_ENTRIES)

`endif

// ==== rtl/bp_pkg.sv ====
`default_nettype none

package bp_pkg;

    `include "bp_settings.svh"

    // Two-bit saturating counter, upper bit is the taken prediction
    typedef enum logic [1:0] {
        STRONG_NT = 2'd0,
        WEAK_NT   = 2'd1,
        WEAK_T    = 2'd2,
        STRONG_T  = 2'd3
    } pht_state_t;

    typedef logic [`BP_XLEN-1:0] addr_t;

    typedef logic [`BP_INDEX_W-1:0] bp_index_t;

    // Report that won the resolve priority this cycle
    typedef enum logic [1:0] {
        KIND_NONE   = 2'd0,
        KIND_BRANCH = 2'd1,
        KIND_JALR   = 2'd2,
        KIND_JAL    = 2'd3
    } resolve_kind_t;

endpackage

`default_nettype wire

// ==== rtl/pred_table.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "bp_settings.svh"

module pred_table
    import bp_pkg::*;
#(
    parameter type    entry_t     = logic [1:0],
    parameter entry_t RESET_VALUE = entry_t'(0)
) (
    input  wire logic      clk,
    input  wire logic      rst_n,

    // Write port
    input  wire logic      we_i,
    input  wire bp_index_t waddr_i,
    input  wire entry_t    wdata_i,

    // Read ports
    input  wire bp_index_t raddr_a_i,
    input  wire bp_index_t raddr_b_i,
    output entry_t         rdata_a_o,
    output entry_t         rdata_b_o
);

    entry_t mem [`BP_ENTRIES];

    // Whole table clears on reset, otherwise one entry per edge
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < `BP_ENTRIES; i++) begin
                mem[i] <= RESET_VALUE;
            end
        end else if (we_i) begin
            mem[waddr_i] <= wdata_i;
        end
    end

    // Reads see the stored value, so a same-cycle write shows up next cycle
    assign rdata_a_o = mem[raddr_a_i];
    assign rdata_b_o = mem[raddr_b_i];

endmodule

`default_nettype wire

// ==== rtl/resolve_update.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "bp_settings.svh"

module resolve_update
    import bp_pkg::*;
(
    // Conditional branch report
    input  wire logic       is_branch_i,
    input  wire logic       branch_taken_i,
    input  wire addr_t      branch_pc_i,
    input  wire addr_t      branch_target_i,

    // Indirect jump report
    input  wire logic       is_jalr_i,
    input  wire addr_t      jalr_pc_i,
    input  wire addr_t      jalr_target_i,

    // Direct jump report
    input  wire logic       is_jal_i,
    input  wire addr_t      jal_pc_i,
    input  wire addr_t      jal_target_i,

    // Counter currently stored at upd_index_o
    input  wire pht_state_t cur_state_i,

    output bp_index_t       upd_index_o,
    output logic            state_we_o,
    output pht_state_t      next_state_o,
    output logic            target_we_o,
    output addr_t           target_o,
    output resolve_kind_t   kind_o
);

    resolve_kind_t kind;
    addr_t         sel_pc;
    addr_t         sel_target;
    logic          step_up;

    // Branch beats jalr, jalr beats jal
    always_comb begin
        if (is_branch_i) begin
            kind = KIND_BRANCH;
        end else if (is_jalr_i) begin
            kind = KIND_JALR;
        end else if (is_jal_i) begin
            kind = KIND_JAL;
        end else begin
            kind = KIND_NONE;
        end
    end

    always_comb begin
        case (kind)
            KIND_JALR: begin
                sel_pc     = jalr_pc_i;
                sel_target = jalr_target_i;
            end
            KIND_JAL: begin
                sel_pc     = jal_pc_i;
                sel_target = jal_target_i;
            end
            default: begin
                sel_pc     = branch_pc_i;
                sel_target = branch_target_i;
            end
        endcase
    end

    // Jumps always count as taken, only a not-taken branch steps down
    assign step_up = (kind != KIND_NONE) && !((kind == KIND_BRANCH) && !branch_taken_i);

    always_comb begin
        if (step_up) begin
            if (cur_state_i == STRONG_T) begin
                next_state_o = cur_state_i;
            end else begin
                next_state_o = pht_state_t'(cur_state_i + 2'd1);
            end
        end else begin
            if (cur_state_i == STRONG_NT) begin
                next_state_o = cur_state_i;
            end else begin
                next_state_o = pht_state_t'(cur_state_i - 2'd1);
            end
        end
    end

    // Bit 0 is ignored, halfword-aligned index
    assign upd_index_o = sel_pc[`BP_INDEX_W:1];
    assign state_we_o  = (kind != KIND_NONE);
    assign target_we_o = step_up;
    assign target_o    = sel_target;
    assign kind_o      = kind;

endmodule

`default_nettype wire

// ==== rtl/branch_predictor.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "bp_settings.svh"

module branch_predictor
    import bp_pkg::*;
(
    input  wire logic  clk,
    input  wire logic  rst_n,

    // Fetch lookup
    input  wire addr_t pc_i,
    input  wire logic  is_jump_i,

    // Branch resolve
    input  wire addr_t branch_pc_i,
    input  wire logic  branch_taken_i,
    input  wire logic  is_branch_i,
    input  wire addr_t branch_target_i,

    // Jal resolve
    input  wire addr_t jal_pc_i,
    input  wire logic  is_jal_i,
    input  wire addr_t jal_target_i,

    // Jalr resolve
    input  wire addr_t jalr_pc_i,
    input  wire logic  is_jalr_i,
    input  wire addr_t jalr_target_i,

    output logic       prediction_taken_o,
    output addr_t      target_o
);

    bp_index_t     fetch_index;
    pht_state_t    fetch_state;
    addr_t         fetch_target;

    bp_index_t     upd_index;
    pht_state_t    upd_cur_state;
    pht_state_t    upd_next_state;
    logic          state_we;
    logic          target_we;
    addr_t         upd_target;
    resolve_kind_t upd_kind;

    assign fetch_index = pc_i[`BP_INDEX_W:1];

    resolve_update u_resolve (
        .is_branch_i     (is_branch_i),
        .branch_taken_i  (branch_taken_i),
        .branch_pc_i     (branch_pc_i),
        .branch_target_i (branch_target_i),
        .is_jalr_i       (is_jalr_i),
        .jalr_pc_i       (jalr_pc_i),
        .jalr_target_i   (jalr_target_i),
        .is_jal_i        (is_jal_i),
        .jal_pc_i        (jal_pc_i),
        .jal_target_i    (jal_target_i),
        .cur_state_i     (upd_cur_state),
        .upd_index_o     (upd_index),
        .state_we_o      (state_we),
        .next_state_o    (upd_next_state),
        .target_we_o     (target_we),
        .target_o        (upd_target),
        .kind_o          (upd_kind)
    );

    // Counters, port B feeds the update's read-modify-write
    pred_table #(
        .entry_t     (pht_state_t),
        .RESET_VALUE (STRONG_NT)
    ) u_state_table (
        .clk       (clk),
        .rst_n     (rst_n),
        .we_i      (state_we),
        .waddr_i   (upd_index),
        .wdata_i   (upd_next_state),
        .raddr_a_i (fetch_index),
        .raddr_b_i (upd_index),
        .rdata_a_o (fetch_state),
        .rdata_b_o (upd_cur_state)
    );

    // Targets are write-only on the update side
    pred_table #(
        .entry_t     (addr_t),
        .RESET_VALUE ('0)
    ) u_target_table (
        .clk       (clk),
        .rst_n     (rst_n),
        .we_i      (target_we),
        .waddr_i   (upd_index),
        .wdata_i   (upd_target),
        .raddr_a_i (fetch_index),
        .raddr_b_i (upd_index),
        .rdata_a_o (fetch_target),
        .rdata_b_o ()
    );

    // Predict taken only when fetch flags a jump
    assign prediction_taken_o = fetch_state[1] & is_jump_i;
    assign target_o           = fetch_target;

endmodule

`default_nettype wire

// ==== testbench/branch_predictor_assert.sv ====
`timescale 1ns/1ps
`default_nettype none

module branch_predictor_assert
    import bp_pkg::*;
(
    input wire logic          clk,
    input wire logic          rst_n,
    input wire logic          is_jump_i,
    input wire logic          prediction_taken_i,
    input wire logic          is_branch_i,
    input wire logic          is_jalr_i,
    input wire logic          is_jal_i,
    input wire logic          branch_taken_i,
    input wire logic          state_we_i,
    input wire logic          target_we_i,
    input wire resolve_kind_t kind_i
);

    // A taken prediction needs the fetch jump hint
    a_taken_needs_jump: assert property (@(posedge clk) disable iff (!rst_n)
        prediction_taken_i |-> is_jump_i)
        else $error("prediction taken while is_jump_i is low");

    // Counters come out of reset at strong not taken
    a_not_taken_after_reset: assert property (@(posedge clk)
        !rst_n |=> !prediction_taken_i)
        else $error("prediction taken in the cycle after reset");

    // Any resolve strobe names a winner and writes its counter
    a_state_written: assert property (@(posedge clk) disable iff (!rst_n)
        (is_branch_i || is_jalr_i || is_jal_i) |-> (kind_i != KIND_NONE && state_we_i))
        else $error("resolve report without a counter write");

    // Not-taken branch keeps its stored target
    a_no_target_on_not_taken: assert property (@(posedge clk) disable iff (!rst_n)
        (is_branch_i && !branch_taken_i) |-> !target_we_i)
        else $error("target written for a not-taken branch");

endmodule

bind branch_predictor branch_predictor_assert u_assert (
    .clk                (clk),
    .rst_n              (rst_n),
    .is_jump_i          (is_jump_i),
    .prediction_taken_i (prediction_taken_o),
    .is_branch_i        (is_branch_i),
    .is_jalr_i          (is_jalr_i),
    .is_jal_i           (is_jal_i),
    .branch_taken_i     (branch_taken_i),
    .state_we_i         (state_we),
    .target_we_i        (target_we),
    .kind_i             (upd_kind)
);

`default_nettype wire

// ==== testbench/branch_predictor_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "bp_settings.svh"

module branch_predictor_tb
    import bp_pkg::*;
();

    localparam int IDX_W        = `BP_INDEX_W;
    localparam int RANDOM_STEPS = 200;

    localparam addr_t Z   = '0;
    localparam addr_t P_A = 32'h0000_0104;
    localparam addr_t P_B = 32'h0000_0200;
    localparam addr_t P_C = 32'h0000_0300;
    localparam addr_t P_D = 32'h0000_0040;
    localparam addr_t P_E = 32'h0000_0050;
    localparam addr_t T_1 = 32'h0000_2000;
    localparam addr_t T_2 = 32'h0000_3000;
    localparam addr_t T_3 = 32'h0000_3400;
    localparam addr_t T_4 = 32'h0000_4000;
    localparam addr_t T_5 = 32'h0000_5000;
    localparam addr_t T_6 = 32'h0000_6000;
    localparam addr_t T_X = 32'hDEAD_0000;

    // Strobes are {branch, jalr, jal}
    typedef struct packed {
        logic [2:0] strobes;
        logic       taken;
        addr_t      br_pc;
        addr_t      br_tgt;
        addr_t      jr_pc;
        addr_t      jr_tgt;
        addr_t      j_pc;
        addr_t      j_tgt;
        addr_t      pc;
        logic       jump;
        logic       exp_taken;
        addr_t      exp_target;
    } step_t;

    logic  clk = 1'b0;
    logic  rst_n;
    logic  is_jump_i, is_branch_i, branch_taken_i, is_jal_i, is_jalr_i;
    addr_t pc_i, branch_pc_i, branch_target_i, jal_pc_i, jal_target_i;
    addr_t jalr_pc_i, jalr_target_i;
    logic  prediction_taken_o;
    addr_t target_o;

    step_t       steps[$];
    string       names[$];
    logic [1:0]  model_state [`BP_ENTRIES];
    addr_t       model_target [`BP_ENTRIES];
    logic [15:0] lfsr = 16'd46325;
    int          cycles = 0;
    int          cycle_limit = 1000;

    branch_predictor u_dut (.*);

    always #5 clk = ~clk;

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles > cycle_limit) begin
            $display("Timeout: the run did not finish within %0d cycles", cycle_limit);
            stop_on_failure();
        end
    end

    task automatic stop_on_failure();
        $display("Test failures found");
        $fatal(1, "simulation stopped at the first failure");
    endtask

    task automatic check_taken(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("ERR %s: taken expected %0b actual %0b", name, exp, act);
            stop_on_failure();
        end
    endtask

    task automatic check_target(input string name, input addr_t exp, input addr_t act);
        if (act !== exp) begin
            $display("ERR %s: target expected %08h actual %08h", name, exp, act);
            stop_on_failure();
        end
    endtask

    // Galois LFSR, x^16 + x^14 + x^13 + x^11 + 1, one step per bit
    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] r;
        logic        b;
        int          k;
        r = '0;
        for (k = 0; k < n; k++) begin
            b    = lfsr[0];
            lfsr = lfsr >> 1;
            if (b) begin
                lfsr = lfsr ^ 16'hB400;
            end
            r = {r[30:0], b};
        end
        return r;
    endfunction

    // Eight indices only, with random bit 0 and bits above the index
    function automatic addr_t pick_pc();
        logic [31:0] idx;
        logic [31:0] lo;
        logic [31:0] hi;
        idx = take_bits(3);
        lo  = take_bits(1);
        hi  = take_bits(2);
        return (hi << 12) | (idx << 1) | lo;
    endfunction

    task automatic put_row(input string name, input logic [2:0] strobes, input logic taken,
                           input addr_t br_pc, input addr_t br_tgt,
                           input addr_t jr_pc, input addr_t jr_tgt,
                           input addr_t j_pc, input addr_t j_tgt,
                           input addr_t pc, input logic jump,
                           input logic exp_taken, input addr_t exp_target);
        step_t s;
        s = '{strobes, taken, br_pc, br_tgt, jr_pc, jr_tgt, j_pc, j_tgt,
              pc, jump, exp_taken, exp_target};
        steps.push_back(s);
        names.push_back(name);
    endtask

    task automatic lookup_only(input string name, input addr_t pc, input logic jump,
                               input logic exp_taken, input addr_t exp_target);
        put_row(name, 3'b000, 1'b0, Z, Z, Z, Z, Z, Z, pc, jump, exp_taken, exp_target);
    endtask

    // Branch report with a lookup of the same PC
    task automatic branch_step(input string name, input logic taken, input addr_t pc,
                               input addr_t tgt, input logic exp_taken, input addr_t exp_target);
        put_row(name, 3'b100, taken, pc, tgt, Z, Z, Z, Z, pc, 1'b1, exp_taken, exp_target);
    endtask

    // Each lookup sees the table as it was before the same row's update
    task automatic build_table();
        lookup_only("reset_a", P_A, 1'b1, 1'b0, Z);
        lookup_only("reset_b", P_B, 1'b1, 1'b0, Z);
        branch_step("br_taken_1", 1'b1, P_A, T_1, 1'b0, Z);
        branch_step("br_taken_2", 1'b1, P_A, T_1, 1'b0, T_1);
        branch_step("br_taken_3", 1'b1, P_A, T_1, 1'b1, T_1);
        branch_step("br_taken_sat", 1'b1, P_A, T_1, 1'b1, T_1);
        branch_step("br_nt_1", 1'b0, P_A, T_X, 1'b1, T_1);
        branch_step("br_nt_2", 1'b0, P_A, T_X, 1'b1, T_1);
        branch_step("br_nt_3", 1'b0, P_A, T_X, 1'b0, T_1);
        branch_step("br_nt_floor", 1'b0, P_A, T_X, 1'b0, T_1);
        lookup_only("br_floor_held", P_A, 1'b1, 1'b0, T_1);
        put_row("jal_write", 3'b001, 1'b0, Z, Z, Z, Z, P_B, T_2, P_B, 1'b1, 1'b0, Z);
        put_row("jalr_write", 3'b010, 1'b0, Z, Z, P_B, T_3, Z, Z, P_B, 1'b1, 1'b0, T_2);
        lookup_only("jalr_seen", P_B, 1'b1, 1'b1, T_3);
        lookup_only("jump_low", P_B, 1'b0, 1'b0, T_3);
        lookup_only("alias_bit0", 32'h0000_0201, 1'b1, 1'b1, T_3);
        lookup_only("alias_high", 32'h8000_0600, 1'b1, 1'b1, T_3);
        put_row("multi_all", 3'b111, 1'b1, P_D, T_4, P_E, T_5, P_C, T_6,
                P_D, 1'b1, 1'b0, Z);
        lookup_only("multi_all_br", P_D, 1'b1, 1'b0, T_4);
        lookup_only("multi_all_jalr", P_E, 1'b1, 1'b0, Z);
        lookup_only("multi_all_jal", P_C, 1'b1, 1'b0, Z);
        put_row("multi_jumps", 3'b011, 1'b0, Z, Z, P_E, T_5, P_C, T_6,
                P_E, 1'b1, 1'b0, Z);
        lookup_only("multi_jumps_jalr", P_E, 1'b1, 1'b0, T_5);
        lookup_only("multi_jumps_jal", P_C, 1'b1, 1'b0, Z);
        branch_step("same_cycle", 1'b1, P_D, T_4, 1'b0, T_4);
        lookup_only("same_cycle_after", P_D, 1'b1, 1'b1, T_4);
    endtask

    task automatic drive_inputs(input step_t s);
        is_branch_i     = s.strobes[2];
        is_jalr_i       = s.strobes[1];
        is_jal_i        = s.strobes[0];
        branch_taken_i  = s.taken;
        branch_pc_i     = s.br_pc;
        branch_target_i = s.br_tgt;
        jalr_pc_i       = s.jr_pc;
        jalr_target_i   = s.jr_tgt;
        jal_pc_i        = s.j_pc;
        jal_target_i    = s.j_tgt;
        pc_i            = s.pc;
        is_jump_i       = s.jump;
    endtask

    // Sample one ns before the rising edge, ahead of this row's write
    task automatic run_step(input string name, input step_t s);
        @(negedge clk);
        drive_inputs(s);
        #4;
        check_taken(name, s.exp_taken, prediction_taken_o);
        check_target(name, s.exp_target, target_o);
    endtask

    task automatic model_update(input step_t s);
        addr_t     rpc;
        addr_t     rtgt;
        logic      up;
        logic      valid;
        bp_index_t idx;
        valid = 1'b1;
        rpc   = s.j_pc;
        rtgt  = s.j_tgt;
        up    = 1'b1;
        if (s.strobes[2]) begin
            rpc  = s.br_pc;
            rtgt = s.br_tgt;
            up   = s.taken;
        end else if (s.strobes[1]) begin
            rpc  = s.jr_pc;
            rtgt = s.jr_tgt;
        end else if (!s.strobes[0]) begin
            valid = 1'b0;
        end
        idx = rpc[IDX_W:1];
        if (valid && up) begin
            if (model_state[idx] != 2'd3) begin
                model_state[idx] = model_state[idx] + 2'd1;
            end
            model_target[idx] = rtgt;
        end else if (valid && model_state[idx] != 2'd0) begin
            model_state[idx] = model_state[idx] - 2'd1;
        end
    endtask

    task automatic random_step(output step_t s);
        bp_index_t idx;
        s.strobes    = 3'(take_bits(3));
        s.taken      = 1'(take_bits(1));
        s.br_pc      = pick_pc();
        s.br_tgt     = take_bits(32);
        s.jr_pc      = pick_pc();
        s.jr_tgt     = take_bits(32);
        s.j_pc       = pick_pc();
        s.j_tgt      = take_bits(32);
        s.pc         = pick_pc();
        s.jump       = 1'(take_bits(1));
        idx          = s.pc[IDX_W:1];
        s.exp_taken  = model_state[idx][1] & s.jump;
        s.exp_target = model_target[idx];
    endtask

    initial begin
        step_t s;
        int    i;
        rst_n = 1'b0;
        drive_inputs('0);
        // Jump hint stays high through reset so the cleared counter shows
        is_jump_i = 1'b1;
        build_table();
        cycle_limit = steps.size() + RANDOM_STEPS + 50;
        for (i = 0; i < `BP_ENTRIES; i++) begin
            model_state[i]  = 2'd0;
            model_target[i] = Z;
        end

        repeat (3) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        for (i = 0; i < steps.size(); i++) begin
            run_step(names[i], steps[i]);
            model_update(steps[i]);
        end

        for (i = 0; i < RANDOM_STEPS; i++) begin
            random_step(s);
            run_step($sformatf("rand_%0d", i), s);
            model_update(s);
        end

        $display("All tests passed!");
        $finish;
    end

endmodule

`default_nettype wire

// ==== branch_predictor.f ====
+incdir+rtl
rtl/bp_pkg.sv
rtl/pred_table.sv
rtl/resolve_update.sv
rtl/branch_predictor.sv
testbench/branch_predictor_assert.sv
testbench/branch_predictor_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the branch predictor testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert \
    --top-module branch_predictor_tb \
    -f branch_predictor.f

./obj_dir/Vbranch_predictor_tb | tee sim.log

if grep -qF "All tests passed!" sim.log; then
    echo "Simulation PASSED"
else
    echo "Simulation FAILED"
    exit 1
fi
